//--- source/uart_link_pkg.sv
// ================================================
// UART string link package
// Bit timing, frame limits, delimiter byte and the
// state types shared by the link blocks
// ================================================
package uart_link_pkg;

	localparam int clks_per_bit = 16;            // Clock cycles per serial bit
	localparam int max_len      = 16;            // Payload bytes per frame
	localparam int str_bits     = max_len * 8;
	localparam logic [7:0] frame_char = 8'h26;   // ASCII '&'

	// Bit-time counter and its compare points
	typedef logic [$clog2(clks_per_bit)-1:0] bit_cnt_t;
	localparam bit_cnt_t bit_last = bit_cnt_t'(clks_per_bit - 1);
	localparam bit_cnt_t bit_mid  = bit_cnt_t'(clks_per_bit / 2 - 1);

	typedef logic [str_bits-1:0] link_str_t;     // Byte k at [8k+7:8k]
	typedef logic [4:0]          link_len_t;     // 0 to 16

	typedef enum logic [1:0] {
		bit_idle, bit_start, bit_data, bit_stop
	} bit_state_t;

	typedef enum logic [2:0] {
		bld_idle, bld_head1, bld_head2, bld_payload,
		bld_tail1, bld_tail2, bld_finish
	} build_state_t;

	typedef enum logic [2:0] {
		prs_hunt, prs_head2, prs_payload, prs_amp_seen, prs_finish
	} parse_state_t;

endpackage

//--- source/uart_bit_tx.sv
// ================================================
// UART bit transmitter
// Sends one byte as start, 8 data bits LSB first
// and one stop bit
// ================================================
`timescale 1ns/100ps

module uart_bit_tx (
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic [7:0] byte_data,
	input  logic       byte_valid,
	output logic       byte_ready,
	output logic       uart_tx_port
);
	import uart_link_pkg::*;

	bit_state_t state;
	bit_cnt_t   clk_cnt;
	logic [2:0] bit_idx;
	logic [7:0] shift_reg;   // Byte being serialized

	assign byte_ready = (state == bit_idle);

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state        <= bit_idle;
			clk_cnt      <= '0;
			bit_idx      <= '0;
			uart_tx_port <= 1'b1;   // Line idles high
		end else begin
			case (state)
				bit_idle: begin
					clk_cnt <= '0;
					if (byte_valid) begin
						state        <= bit_start;
						uart_tx_port <= 1'b0;
					end
				end
				bit_start: begin
					clk_cnt <= clk_cnt + 1'b1;
					if (clk_cnt == bit_last) begin
						state        <= bit_data;
						clk_cnt      <= '0;
						bit_idx      <= '0;
						uart_tx_port <= shift_reg[0];
					end
				end
				bit_data: begin
					clk_cnt <= clk_cnt + 1'b1;
					if (clk_cnt == bit_last) begin
						clk_cnt <= '0;
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7) begin
							state        <= bit_stop;
							uart_tx_port <= 1'b1;
						end else begin
							uart_tx_port <= shift_reg[1];   // Next bit after the shift
						end
					end
				end
				bit_stop: begin
					clk_cnt <= clk_cnt + 1'b1;
					if (clk_cnt == bit_last)
						state <= bit_idle;
				end
				default: state <= bit_idle;
			endcase
		end
	end

	always_ff @(posedge sys_clk) begin
		if (state == bit_idle && byte_valid)
			shift_reg <= byte_data;
		else if (state == bit_data && clk_cnt == bit_last)
			shift_reg <= {1'b0, shift_reg[7:1]};
	end

	// Ready returns exactly one frame time after each accepted byte
	a_frame_time: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		$rose(byte_ready) |-> $past(byte_valid && byte_ready, 10 * clks_per_bit + 1));

endmodule

//--- source/uart_bit_rx.sv
// ================================================
// UART bit receiver
// Synchronizes the serial input, samples each bit
// at mid-bit and outputs one pulse per good byte
// ================================================
`timescale 1ns/100ps

module uart_bit_rx (
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic       uart_rx_port,
	output logic [7:0] rx_byte,
	output logic       rx_byte_valid
);
	import uart_link_pkg::*;

	logic       rx_meta;
	logic       rx_sync;
	logic       rx_prev;
	logic       start_edge;
	bit_state_t state;
	bit_cnt_t   clk_cnt;
	logic [2:0] bit_idx;
	logic [7:0] shift_reg;

	// Two-flop synchronizer plus one stage for edge detect
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
		end else begin
			rx_meta <= uart_rx_port;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
		end
	end

	assign start_edge = rx_prev && !rx_sync;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state         <= bit_idle;
			clk_cnt       <= '0;
			bit_idx       <= '0;
			rx_byte_valid <= 1'b0;
		end else begin
			rx_byte_valid <= 1'b0;
			case (state)
				bit_idle: begin
					clk_cnt <= '0;
					if (start_edge)
						state <= bit_start;
				end
				bit_start: begin
					clk_cnt <= clk_cnt + 1'b1;
					if (clk_cnt == bit_mid) begin
						clk_cnt <= '0;
						bit_idx <= '0;
						state   <= rx_sync ? bit_idle : bit_data;   // Glitch rejected
					end
				end
				bit_data: begin
					clk_cnt <= clk_cnt + 1'b1;
					if (clk_cnt == bit_last) begin
						clk_cnt <= '0;
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7)
							state <= bit_stop;
					end
				end
				bit_stop: begin
					clk_cnt <= clk_cnt + 1'b1;
					if (clk_cnt == bit_last) begin
						state         <= bit_idle;
						rx_byte_valid <= rx_sync;   // Framing error drops the byte
					end
				end
				default: state <= bit_idle;
			endcase
		end
	end

	always_ff @(posedge sys_clk) begin
		if (state == bit_data && clk_cnt == bit_last)
			shift_reg <= {rx_sync, shift_reg[7:1]};   // LSB arrives first
		if (state == bit_stop && clk_cnt == bit_last)
			rx_byte <= shift_reg;
	end

endmodule

//--- source/frame_builder.sv
// ================================================
// Frame builder
// Turns a host string request into "&&", payload
// bytes and "&&" for the bit transmitter
// ================================================
`timescale 1ns/100ps

module frame_builder (
	input  logic                     sys_clk,
	input  logic                     sys_rst_n,
	input  uart_link_pkg::link_str_t tx_string,
	input  uart_link_pkg::link_len_t tx_length,
	input  logic                     tx_req,
	output logic                     tx_busy,
	output logic                     tx_done,
	output logic [7:0]               byte_data,
	output logic                     byte_valid,
	input  logic                     byte_ready
);
	import uart_link_pkg::*;

	build_state_t state;
	link_str_t    str_q;
	link_len_t    len_q;
	link_len_t    byte_cnt;   // Index of the payload byte on offer
	logic         fire;

	assign tx_busy    = (state != bld_idle);
	assign byte_valid = (state != bld_idle) && (state != bld_finish);
	assign byte_data  = (state == bld_payload) ?
		str_q[{byte_cnt[3:0], 3'b000} +: 8] : frame_char;
	assign fire       = byte_valid && byte_ready;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state    <= bld_idle;
			len_q    <= '0;
			byte_cnt <= '0;
			tx_done  <= 1'b0;
		end else begin
			tx_done <= 1'b0;
			case (state)
				bld_idle: begin
					byte_cnt <= '0;
					if (tx_req) begin
						state <= bld_head1;
						len_q <= (tx_length > link_len_t'(max_len)) ?
							link_len_t'(max_len) : tx_length;   // Clamp oversize requests
					end
				end
				bld_head1: if (fire) state <= bld_head2;
				bld_head2: if (fire) state <= (len_q == '0) ? bld_tail1 : bld_payload;
				bld_payload: begin
					if (fire) begin
						byte_cnt <= byte_cnt + 1'b1;
						if (byte_cnt + 1'b1 == len_q)
							state <= bld_tail1;
					end
				end
				bld_tail1: if (fire) state <= bld_tail2;
				bld_tail2: if (fire) state <= bld_finish;
				bld_finish: begin
					// Last stop bit is out once the transmitter is idle
					if (byte_ready) begin
						state   <= bld_idle;
						tx_done <= 1'b1;
					end
				end
				default: state <= bld_idle;
			endcase
		end
	end

	always_ff @(posedge sys_clk) begin
		if (state == bld_idle && tx_req)
			str_q <= tx_string;
	end

endmodule

//--- source/frame_parser.sv
// ================================================
// Frame parser
// Finds "&&" delimiters in received bytes and
// assembles the payload string, length and overflow
// ================================================
`timescale 1ns/100ps

module frame_parser (
	input  logic                     sys_clk,
	input  logic                     sys_rst_n,
	input  logic [7:0]               rx_byte,
	input  logic                     rx_byte_valid,
	output uart_link_pkg::link_str_t rx_string,
	output uart_link_pkg::link_len_t rx_length,
	output logic                     rx_done,
	output logic                     rx_overflow
);
	import uart_link_pkg::*;

	parse_state_t state;
	logic         is_amp;
	logic         got_amp;
	logic         got_other;
	link_len_t    len_plus1;
	link_len_t    len_plus2;
	logic         room1;   // Space for one more byte
	logic         room2;   // Space for two more bytes

	assign is_amp    = (rx_byte == frame_char);
	assign got_amp   = rx_byte_valid && is_amp;
	assign got_other = rx_byte_valid && !is_amp;
	assign len_plus1 = rx_length + 5'd1;
	assign len_plus2 = rx_length + 5'd2;
	assign room1     = (rx_length < link_len_t'(max_len));
	assign room2     = (rx_length < link_len_t'(max_len - 1));

	assign rx_done = (state == prs_finish);   // Cycle after the closing '&'

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state       <= prs_hunt;
			rx_string   <= '0;
			rx_length   <= '0;
			rx_overflow <= 1'b0;
		end else begin
			case (state)
				prs_hunt: if (got_amp) state <= prs_head2;
				prs_head2: begin
					if (got_amp) begin
						state       <= prs_payload;   // Frame opens
						rx_string   <= '0;
						rx_length   <= '0;
						rx_overflow <= 1'b0;
					end else if (rx_byte_valid) begin
						state <= prs_hunt;
					end
				end
				prs_payload: begin
					if (got_amp) begin
						state <= prs_amp_seen;
					end else if (got_other) begin
						if (room1) begin
							rx_string[{rx_length[3:0], 3'b000} +: 8] <= rx_byte;
							rx_length <= len_plus1;
						end else begin
							rx_overflow <= 1'b1;
						end
					end
				end
				prs_amp_seen: begin
					if (got_amp) begin
						state <= prs_finish;
					end else if (got_other) begin
						// Lone '&' was payload, keep it ahead of this byte
						state <= prs_payload;
						if (room1)
							rx_string[{rx_length[3:0], 3'b000} +: 8] <= frame_char;
						if (room2) begin
							rx_string[{len_plus1[3:0], 3'b000} +: 8] <= rx_byte;
							rx_length <= len_plus2;
						end else begin
							rx_overflow <= 1'b1;
							if (room1)
								rx_length <= len_plus1;
						end
					end
				end
				prs_finish: state <= prs_hunt;
				default: state <= prs_hunt;
			endcase
		end
	end

	a_len_bound: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		rx_length <= link_len_t'(max_len));

endmodule

//--- source/uart_link_top.sv
// ================================================
// UART string link top level
// Receive path into the frame parser, frame builder
// out through the bit transmitter
// ================================================
`timescale 1ns/100ps

module uart_link_top (
	input  logic                     sys_clk,
	input  logic                     sys_rst_n,
	input  uart_link_pkg::link_str_t tx_string,
	input  uart_link_pkg::link_len_t tx_length,
	input  logic                     tx_req,
	output logic                     tx_busy,
	output logic                     tx_done,
	output uart_link_pkg::link_str_t rx_string,
	output uart_link_pkg::link_len_t rx_length,
	output logic                     rx_done,
	output logic                     rx_overflow,
	input  logic                     uart_rx_port,
	output logic                     uart_tx_port
);

	logic [7:0] rx_byte;
	logic       rx_byte_valid;
	logic [7:0] byte_data;
	logic       byte_valid;
	logic       byte_ready;

	// Receive side
	uart_bit_rx u_uart_bit_rx (
		.sys_clk       (sys_clk),
		.sys_rst_n     (sys_rst_n),
		.uart_rx_port  (uart_rx_port),
		.rx_byte       (rx_byte),
		.rx_byte_valid (rx_byte_valid)
	);

	frame_parser u_frame_parser (
		.sys_clk       (sys_clk),
		.sys_rst_n     (sys_rst_n),
		.rx_byte       (rx_byte),
		.rx_byte_valid (rx_byte_valid),
		.rx_string     (rx_string),
		.rx_length     (rx_length),
		.rx_done       (rx_done),
		.rx_overflow   (rx_overflow)
	);

	// Transmit side
	frame_builder u_frame_builder (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.tx_string  (tx_string),
		.tx_length  (tx_length),
		.tx_req     (tx_req),
		.tx_busy    (tx_busy),
		.tx_done    (tx_done),
		.byte_data  (byte_data),
		.byte_valid (byte_valid),
		.byte_ready (byte_ready)
	);

	uart_bit_tx u_uart_bit_tx (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.byte_data    (byte_data),
		.byte_valid   (byte_valid),
		.byte_ready   (byte_ready),
		.uart_tx_port (uart_tx_port)
	);

endmodule

//--- verif/tb_uart_link.sv
// ==================================================
// UART string link testbench
// Directed tests for transmit framing, receive parsing,
// overflow and loopback over the serial lines
// ==================================================
`timescale 1ns/100ps

module tb_uart_link;
	import uart_link_pkg::*;

	typedef logic [7:0] byte_q_t[$];

	localparam int test_bytes = 98;   // Serial bytes over all tests including idle gaps
	localparam int run_limit  = test_bytes * 10 * clks_per_bit + 2000;
	localparam int wait_limit = (max_len + 5) * 10 * clks_per_bit + 200;

	logic      sys_clk = 1'b0;
	logic      sys_rst_n;
	link_str_t tx_string;
	link_len_t tx_length;
	logic      tx_req;
	logic      tx_busy;
	logic      tx_done;
	link_str_t rx_string;
	link_len_t rx_length;
	logic      rx_done;
	logic      rx_overflow;
	logic      uart_tx_port;
	logic      drv_line;   // Driven by the serial driver task
	logic      loopback;
	logic      rx_line;

	int        seed = 32'h0c9711dc;
	int        err_cnt = 0;
	int        pass_cnt = 0;
	int        fail_cnt = 0;
	int        cycle_cnt = 0;
	int        rx_done_cnt = 0;
	int        tx_done_cnt = 0;
	link_str_t cap_str;   // Receive outputs seen at the rx_done pulse
	link_len_t cap_len;
	logic      cap_ovf;
	byte_q_t   mon_q;     // Bytes decoded from uart_tx_port

	assign rx_line = loopback ? uart_tx_port : drv_line;

	uart_link_top u_uart_link_top (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.tx_string    (tx_string),
		.tx_length    (tx_length),
		.tx_req       (tx_req),
		.tx_busy      (tx_busy),
		.tx_done      (tx_done),
		.rx_string    (rx_string),
		.rx_length    (rx_length),
		.rx_done      (rx_done),
		.rx_overflow  (rx_overflow),
		.uart_rx_port (rx_line),
		.uart_tx_port (uart_tx_port)
	);

	always #10 sys_clk = ~sys_clk;

	always @(posedge sys_clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt == run_limit) begin
			$display("Run timed out after %0d cycles without finishing the tests", cycle_cnt);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	// Count done pulses mid-cycle and keep what the receiver reported
	always @(negedge sys_clk) begin
		if (tx_done)
			tx_done_cnt <= tx_done_cnt + 1;
		if (rx_done) begin
			rx_done_cnt <= rx_done_cnt + 1;
			cap_str     <= rx_string;
			cap_len     <= rx_length;
			cap_ovf     <= rx_overflow;
		end
	end

	always begin
		wait (sys_rst_n === 1'b1);
		capture_tx_byte();
	end

	task automatic note_error(input string msg);
		$display("Error at %0t: %s", $time, msg);
		err_cnt++;
	endtask

	task automatic compare_str(input link_str_t got, input link_str_t exp, input string what);
		if (got !== exp) begin
			$display("[FAIL] %0t: %s is %h, expected %h", $time, what, got, exp);
			err_cnt++;
		end
	endtask

	task automatic compare_len(input link_len_t got, input link_len_t exp, input string what);
		if (got !== exp) begin
			$display("[FAIL] %0t: %s is %0d, expected %0d", $time, what, got, exp);
			err_cnt++;
		end
	endtask

	task automatic compare_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
		if (got !== exp) begin
			$display("[FAIL] %0t: %s is %h, expected %h", $time, what, got, exp);
			err_cnt++;
		end
	endtask

	task automatic compare_bit(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("[FAIL] %0t: %s is %b, expected %b", $time, what, got, exp);
			err_cnt++;
		end
	endtask

	function automatic logic [7:0] rand_byte();
		logic [7:0] b;
		do
			b = 8'($random(seed));
		while (b == frame_char);   // Payloads avoid the delimiter
		return b;
	endfunction

	function automatic byte_q_t str_to_q(input string s);
		byte_q_t q;
		for (int i = 0; i < s.len(); i++)
			q.push_back(s[i]);
		return q;
	endfunction

	// "&&" + payload + "&&"
	function automatic byte_q_t frame_q(input byte_q_t pl);
		byte_q_t q;
		q.push_back(frame_char);
		q.push_back(frame_char);
		foreach (pl[i])
			q.push_back(pl[i]);
		q.push_back(frame_char);
		q.push_back(frame_char);
		return q;
	endfunction

	// Byte k lands at [8k+7:8k] and bytes past max_len are dropped
	function automatic link_str_t pack_str(input byte_q_t q);
		link_str_t s;
		s = '0;
		for (int k = 0; k < q.size() && k < max_len; k++)
			s[k*8 +: 8] = q[k];
		return s;
	endfunction

	task automatic send_bytes(input byte_q_t q);
		logic [9:0] bits;
		foreach (q[n]) begin
			bits = {1'b1, q[n], 1'b0};   // Stop, data LSB first, start
			for (int i = 0; i < 10; i++) begin
				@(posedge sys_clk);
				#2;
				drv_line = bits[i];
				repeat (clks_per_bit - 1) @(posedge sys_clk);
			end
		end
	endtask

	task automatic send_frame(input byte_q_t pl);
		send_bytes(frame_q(pl));
	endtask

	task automatic capture_tx_byte();
		logic [7:0] b;
		@(negedge uart_tx_port);
		repeat (clks_per_bit / 2) @(negedge sys_clk);   // Middle of the start bit
		if (uart_tx_port !== 1'b0) begin
			note_error("start bit on uart_tx_port did not stay low");
		end else begin
			for (int i = 0; i < 8; i++) begin
				repeat (clks_per_bit) @(negedge sys_clk);
				b[i] = uart_tx_port;
			end
			repeat (clks_per_bit) @(negedge sys_clk);
			compare_bit(uart_tx_port, 1'b1, "uart_tx_port stop bit");
			mon_q.push_back(b);
		end
	endtask

	task automatic request_tx(input byte_q_t pl);
		@(posedge sys_clk);
		#2;
		tx_string = pack_str(pl);
		tx_length = link_len_t'(pl.size());
		tx_req    = 1'b1;
		@(posedge sys_clk);
		#2;
		tx_req = 1'b0;
		compare_bit(tx_busy, 1'b1, "tx_busy after request");
	endtask

	task automatic wait_tx_done();
		int cyc;
		cyc = 0;
		do begin
			@(negedge sys_clk);
			cyc++;
			if (!tx_done)
				compare_bit(tx_busy, 1'b1, "tx_busy during frame");
		end while (!tx_done && cyc < wait_limit);
		if (tx_done)
			compare_bit(tx_busy, 1'b0, "tx_busy at tx_done");
		else
			note_error("tx_done did not arrive in time");
	endtask

	task automatic wait_rx_count(input int n);
		int cyc;
		cyc = 0;
		while (rx_done_cnt < n && cyc < wait_limit) begin
			@(negedge sys_clk);
			cyc++;
		end
		if (rx_done_cnt < n)
			note_error("rx_done did not arrive in time");
	endtask

	task automatic check_tx_bytes(input byte_q_t exp);
		if (mon_q.size() != exp.size()) begin
			note_error($sformatf("uart_tx_port carried %0d bytes, expected %0d",
				mon_q.size(), exp.size()));
		end else begin
			foreach (exp[i])
				compare_byte(mon_q[i], exp[i], $sformatf("uart_tx_port byte %0d", i));
		end
	endtask

	task automatic check_rx(input byte_q_t pl, input logic ovf);
		compare_len(cap_len, link_len_t'(pl.size() > max_len ? max_len : pl.size()), "rx_length");
		compare_str(cap_str, pack_str(pl), "rx_string");
		compare_bit(cap_ovf, ovf, "rx_overflow");
	endtask

	task automatic end_test(input string name, input int err_start);
		if (err_cnt == err_start) begin
			pass_cnt++;
			$display("Test %s: passed at %0t", name, $time);
		end else begin
			fail_cnt++;
			$display("Test %s: failed with %0d errors", name, err_cnt - err_start);
		end
	endtask

	task automatic test_reset();
		int start_err;
		start_err = err_cnt;
		@(negedge sys_clk);
		compare_bit(uart_tx_port, 1'b1, "uart_tx_port after reset");
		compare_bit(tx_busy, 1'b0, "tx_busy after reset");
		compare_bit(tx_done, 1'b0, "tx_done after reset");
		compare_bit(rx_done, 1'b0, "rx_done after reset");
		compare_len(rx_length, 5'd0, "rx_length after reset");
		compare_str(rx_string, '0, "rx_string after reset");
		end_test("reset state", start_err);
	endtask

	task automatic test_tx_framing();
		byte_q_t pl;
		byte_q_t none;
		int      start_err;
		int      n0;
		start_err = err_cnt;
		for (int i = 0; i < 5; i++)
			pl.push_back(rand_byte());
		mon_q.delete();
		n0 = tx_done_cnt;
		request_tx(pl);
		@(posedge sys_clk);
		#2;
		tx_req = 1'b1;   // Ignored while busy
		@(posedge sys_clk);
		#2;
		tx_req = 1'b0;
		wait_tx_done();
		repeat (3 * 10 * clks_per_bit) @(negedge sys_clk);
		check_tx_bytes(frame_q(pl));
		if (tx_done_cnt != n0 + 1)
			note_error($sformatf("saw %0d tx_done pulses, expected 1", tx_done_cnt - n0));
		mon_q.delete();
		request_tx(none);
		wait_tx_done();
		check_tx_bytes(frame_q(none));
		end_test("transmit framing", start_err);
	endtask

	task automatic test_rx_frame();
		byte_q_t pl;
		int      start_err;
		int      n0;
		start_err = err_cnt;
		for (int i = 0; i < 7; i++)
			pl.push_back(rand_byte());
		n0 = rx_done_cnt;
		send_frame(pl);
		wait_rx_count(n0 + 1);
		check_rx(pl, 1'b0);
		repeat (20) @(negedge sys_clk);
		if (rx_done_cnt != n0 + 1)
			note_error("more than one rx_done pulse for a single frame");
		end_test("receive frame", start_err);
	endtask

	task automatic test_delimiters();
		int start_err;
		int n0;
		start_err = err_cnt;
		n0 = rx_done_cnt;
		send_bytes(str_to_q("&x"));   // Lone '&' ahead of a real frame
		send_frame(str_to_q("ab"));
		wait_rx_count(n0 + 1);
		check_rx(str_to_q("ab"), 1'b0);
		send_frame(str_to_q("a&b"));
		wait_rx_count(n0 + 2);
		check_rx(str_to_q("a&b"), 1'b0);
		send_bytes(str_to_q("xyz&w"));
		repeat (20) @(negedge sys_clk);
		if (rx_done_cnt != n0 + 2)
			note_error("rx_done pulsed without an opening pair");
		end_test("delimiter rules", start_err);
	endtask

	task automatic test_overflow();
		byte_q_t pl;
		int      start_err;
		int      n0;
		start_err = err_cnt;
		for (int i = 0; i < 20; i++)
			pl.push_back(rand_byte());
		n0 = rx_done_cnt;
		send_frame(pl);
		wait_rx_count(n0 + 1);
		check_rx(pl, 1'b1);
		send_frame(str_to_q("ok!"));
		wait_rx_count(n0 + 2);
		check_rx(str_to_q("ok!"), 1'b0);
		end_test("overflow", start_err);
	endtask

	task automatic test_loopback();
		byte_q_t pl;
		int      start_err;
		int      n0;
		int      len;
		start_err = err_cnt;
		len = 1 + int'($unsigned($random(seed)) % max_len);
		for (int i = 0; i < len; i++)
			pl.push_back(rand_byte());
		@(posedge sys_clk);
		#2;
		loopback = 1'b1;
		n0 = rx_done_cnt;
		request_tx(pl);
		wait_tx_done();
		wait_rx_count(n0 + 1);
		check_rx(pl, 1'b0);
		@(posedge sys_clk);
		#2;
		loopback = 1'b0;
		mon_q.delete();
		end_test($sformatf("loopback of %0d bytes", len), start_err);
	endtask

	initial begin
		sys_rst_n = 1'b0;
		tx_string = '0;
		tx_length = '0;
		tx_req    = 1'b0;
		drv_line  = 1'b1;   // Serial line idles high
		loopback  = 1'b0;
		repeat (10) @(posedge sys_clk);
		#2;
		sys_rst_n = 1'b1;

		test_reset();
		test_tx_framing();
		test_rx_frame();
		test_delimiters();
		test_overflow();
		test_loopback();

		$display("Tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0 && err_cnt == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

//--- build.f
source/uart_link_pkg.sv
source/uart_bit_tx.sv
source/uart_bit_rx.sv
source/frame_builder.sv
source/frame_parser.sv
source/uart_link_top.sv
verif/tb_uart_link.sv

//--- run.sh
#!/usr/bin/env bash
# Build the UART link testbench with Verilator, run it and check the log
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/100ps \
	--top-module tb_uart_link -f build.f -o tb_uart_link \
	&& ./obj_dir/tb_uart_link | tee sim.log \
	|| { echo "Build or simulation did not complete"; exit 1; }
grep -q "ALL TESTS PASSED" sim.log \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed, see sim.log"; exit 1; }
